// File: hci.f
logic/hci_pkg.sv
logic/hci_fifo.sv
logic/hci_cmd_queue.sv
logic/hci_resp_queue.sv
logic/hci_csr.sv
logic/hci.sv
tests/hci_asserts.sv
tests/hci_checker.sv
tests/hci_tb.sv

// File: run.sh
#!/bin/sh
# Build the HCI testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module hci_tb \
  -f hci.f --Mdir obj_dir -o vhci_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vhci_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tests/hci_tb.sv
/* Testbench for the HCI front end: clock, reset, LFSR stimulus for the
   CSR bus and controller ports, closing report */
`timescale 1ns/1ps

module hci_tb;

  logic                clk_i;
  logic                rst_ni;
  hci_pkg::cpuif_req_t req;
  hci_pkg::cpuif_rsp_t rsp;
  logic                cmd_rvalid, cmd_rready;
  hci_pkg::cmd_data_t  cmd_rdata;
  logic                resp_wvalid, resp_wready;
  hci_pkg::resp_data_t resp_wdata;
  logic                cmd_full, cmd_empty, cmd_thld_trig;
  logic                resp_full, resp_empty, resp_thld_trig;
  int                  test_id;
  int                  tb_err_cnt;
  int                  chk_err_cnt, chk_cnt;
  logic [31:0]         lfsr_q;
  int                  rready_mode;  // 0 low, 1 high, 2 random
  int unsigned         wait_limit = 400;
  hci_pkg::csr_data_t  rd_word;

  hci dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cpuif_req_i      (req),
    .cpuif_rsp_o      (rsp),
    .cmd_rvalid_o     (cmd_rvalid),
    .cmd_rready_i     (cmd_rready),
    .cmd_rdata_o      (cmd_rdata),
    .resp_wvalid_i    (resp_wvalid),
    .resp_wready_o    (resp_wready),
    .resp_wdata_i     (resp_wdata),
    .cmd_full_o       (cmd_full),
    .cmd_empty_o      (cmd_empty),
    .cmd_thld_trig_o  (cmd_thld_trig),
    .resp_full_o      (resp_full),
    .resp_empty_o     (resp_empty),
    .resp_thld_trig_o (resp_thld_trig)
  );

  hci_checker u_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .test_id_i        (test_id),
    .req_i            (req),
    .rsp_i            (rsp),
    .cmd_rvalid_i     (cmd_rvalid),
    .cmd_rready_i     (cmd_rready),
    .cmd_rdata_i      (cmd_rdata),
    .resp_wvalid_i    (resp_wvalid),
    .resp_wready_i    (resp_wready),
    .resp_wdata_i     (resp_wdata),
    .cmd_full_i       (cmd_full),
    .cmd_empty_i      (cmd_empty),
    .cmd_thld_trig_i  (cmd_thld_trig),
    .resp_full_i      (resp_full),
    .resp_empty_i     (resp_empty),
    .resp_thld_trig_i (resp_thld_trig),
    .err_cnt_o        (chk_err_cnt),
    .chk_cnt_o        (chk_cnt)
  );

  always #2 clk_i = ~clk_i;

  // Right-shift Galois form, taps 32 22 2 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = galois_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic finish_run();
    $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
             chk_cnt, chk_err_cnt, tb_err_cnt);
    if (chk_err_cnt == 0 && tb_err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  // Every input change happens 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    case (rready_mode)
      0: cmd_rready = 1'b0;
      1: cmd_rready = 1'b1;
      default: cmd_rready = (rand_bits(1) != 0);
    endcase
  endtask

  task automatic step_guarded(input string what, inout int unsigned n);
    next_cycle();
    n++;
    if (n > wait_limit) begin
      $display("Timeout while waiting for %s", what);
      tb_err_cnt++;
      finish_run();
    end
  endtask

  task automatic csr_access(input logic wr, input hci_pkg::csr_addr_t addr,
                            input hci_pkg::csr_data_t data, output hci_pkg::csr_data_t rdata);
    int unsigned n;
    n = 0;
    next_cycle();
    req.req     = 1'b1;
    req.is_wr   = wr;
    req.addr    = addr;
    req.wr_data = data;
    next_cycle();
    req = '0;
    while (!(rsp.rd_ack || rsp.rd_err || rsp.wr_ack || rsp.wr_err)) begin
      step_guarded("a CSR response", n);
    end
    rdata = rsp.rd_data;
  endtask

  task automatic csr_write(input hci_pkg::csr_addr_t addr, input hci_pkg::csr_data_t data);
    hci_pkg::csr_data_t unused;
    csr_access(1'b1, addr, data, unused);
  endtask

  task automatic send_cmd();
    csr_write(hci_pkg::AddrCmdPort, rand_bits(32));
    csr_write(hci_pkg::AddrCmdPort, rand_bits(32));
  endtask

  task automatic push_resp(input hci_pkg::resp_data_t data);
    int unsigned n;
    n = 0;
    resp_wvalid = 1'b1;
    resp_wdata  = data;
    while (!resp_wready) step_guarded("response queue space", n);
    next_cycle();
    resp_wvalid = 1'b0;
  endtask

  task automatic drain_cmds();
    int unsigned n;
    n = 0;
    rready_mode = 1;
    while (!cmd_empty) step_guarded("command queue to drain", n);
  endtask

  initial begin
    int unsigned n;
    int          k;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req         = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    lfsr_q      = 32'd7;
    rready_mode = 0;
    test_id     = 0;
    tb_err_cnt  = 0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_id = 1;
    rready_mode = 2;
    for (int i = 0; i < 20; i++) begin
      n = 0;
      while (cmd_full) step_guarded("command queue space", n);
      send_cmd();
    end
    rready_mode = 2;
    n = 0;
    while (!cmd_empty) step_guarded("random drain of commands", n);

    test_id = 2;
    rready_mode = 0;
    for (int i = 0; i < 8; i++) send_cmd();
    send_cmd();  // Second word meets a full queue
    csr_access(1'b0, hci_pkg::AddrRespPort, '0, rd_word);
    drain_cmds();

    test_id = 3;
    for (int r = 0; r < 3; r++) begin
      k = int'(rand_bits(3)) + 1;
      for (int i = 0; i < k; i++) push_resp(rand_bits(32));
      for (int i = 0; i < k; i++) csr_access(1'b0, hci_pkg::AddrRespPort, '0, rd_word);
    end
    for (int i = 0; i < 8; i++) push_resp(rand_bits(32));
    resp_wvalid = 1'b1;  // Offered while full
    resp_wdata  = rand_bits(32);
    next_cycle();
    next_cycle();
    resp_wvalid = 1'b0;
    for (int i = 0; i < 8; i++) csr_access(1'b0, hci_pkg::AddrRespPort, '0, rd_word);

    test_id = 4;
    for (int t = 0; t < 6; t++) begin
      csr_write(hci_pkg::AddrThldCtrl, {16'd0, hci_pkg::thld_t'(rand_bits(4)),
                                        hci_pkg::thld_t'(rand_bits(4))});
      repeat (4) next_cycle();
      csr_access(1'b0, hci_pkg::AddrThldCtrl, '0, rd_word);
      rready_mode = 0;
      k = int'(rand_bits(3));
      for (int i = 0; i < k; i++) send_cmd();
      k = int'(rand_bits(3)) + 1;
      for (int i = 0; i < k; i++) push_resp(rand_bits(32));
      for (int i = 0; i < k; i++) csr_access(1'b0, hci_pkg::AddrRespPort, '0, rd_word);
      drain_cmds();
    end

    test_id = 5;
    rready_mode = 0;
    for (int i = 0; i < 3; i++) send_cmd();
    csr_write(hci_pkg::AddrCmdPort, rand_bits(32));  // Lone first word
    for (int i = 0; i < 3; i++) push_resp(rand_bits(32));
    csr_write(hci_pkg::AddrResetCtrl, 32'h0000_0006);
    n = 0;
    rd_word = 32'h0000_0006;
    while ((rd_word & 32'h0000_0006) != 0) begin
      step_guarded("reset bits to clear", n);
      csr_access(1'b0, hci_pkg::AddrResetCtrl, '0, rd_word);
    end
    send_cmd();
    drain_cmds();
    csr_access(1'b0, hci_pkg::AddrRespPort, '0, rd_word);

    test_id = 6;
    csr_write(8'h00, rand_bits(32));
    csr_access(1'b0, 8'h08, '0, rd_word);
    csr_access(1'b0, hci_pkg::AddrCmdPort, '0, rd_word);
    csr_write(hci_pkg::AddrRespPort, rand_bits(32));
    csr_access(1'b0, 8'hFC, '0, rd_word);

    repeat (3) next_cycle();
    finish_run();
  end

endmodule

// File: tests/hci_checker.sv
/* Reference model of both queues, thresholds and reset bits, compared
   with every DUT output at the falling clock edge */
`timescale 1ns/1ps

module hci_checker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  int                  test_id_i,
  input  hci_pkg::cpuif_req_t req_i,
  input  hci_pkg::cpuif_rsp_t rsp_i,
  input  logic                cmd_rvalid_i,
  input  logic                cmd_rready_i,
  input  hci_pkg::cmd_data_t  cmd_rdata_i,
  input  logic                resp_wvalid_i,
  input  logic                resp_wready_i,
  input  hci_pkg::resp_data_t resp_wdata_i,
  input  logic                cmd_full_i,
  input  logic                cmd_empty_i,
  input  logic                cmd_thld_trig_i,
  input  logic                resp_full_i,
  input  logic                resp_empty_i,
  input  logic                resp_thld_trig_i,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);

  hci_pkg::cmd_data_t  cmd_q[$];
  hci_pkg::resp_data_t resp_q[$];
  logic                asm_hi;  // First word held
  hci_pkg::csr_data_t  lo_word;
  hci_pkg::thld_t      cmd_reg, resp_reg;  // Register view
  hci_pkg::thld_t      cmd_eff, resp_eff;  // Value the flags use
  int unsigned         wb_cnt;
  int unsigned         cmd_rst_cnt, resp_rst_cnt;
  logic                exp_rd_ack, exp_rd_err, exp_wr_ack, exp_wr_err;
  hci_pkg::csr_data_t  exp_rd_data;
  int                  err_cnt = 0;
  int                  chk_cnt = 0;

  function automatic string test_name(input int id);
    case (id)
      1: return "cmd_order";
      2: return "full_err";
      3: return "resp_order";
      4: return "threshold";
      5: return "soft_reset";
      6: return "bad_addr";
      default: return "reset_state";
    endcase
  endfunction

  function automatic hci_pkg::thld_t clamp(input hci_pkg::thld_t v, input int unsigned depth);
    if (v == 8'd0) return 8'd1;
    if (int'(v) > int'(depth)) return hci_pkg::thld_t'(depth);
    return v;
  endfunction

  task automatic check_val(input string sig, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s %s: expected %0h, actual %0h", test_name(test_id_i), sig, exp, act);
    end
  endtask

  task automatic reset_model();
    cmd_q.delete();
    resp_q.delete();
    asm_hi       = 1'b0;
    lo_word      = '0;
    cmd_reg      = 8'd1;
    resp_reg     = 8'd1;
    cmd_eff      = 8'd1;
    resp_eff     = 8'd1;
    wb_cnt       = 0;
    cmd_rst_cnt  = 0;
    resp_rst_cnt = 0;
    exp_rd_ack   = 1'b0;
    exp_rd_err   = 1'b0;
    exp_wr_ack   = 1'b0;
    exp_wr_err   = 1'b0;
    exp_rd_data  = '0;
  endtask

  task automatic check_outputs();
    int cmd_n;
    int resp_n;
    cmd_n  = cmd_q.size();
    resp_n = resp_q.size();
    check_val("rd_ack", 64'(exp_rd_ack), 64'(rsp_i.rd_ack));
    check_val("rd_err", 64'(exp_rd_err), 64'(rsp_i.rd_err));
    check_val("wr_ack", 64'(exp_wr_ack), 64'(rsp_i.wr_ack));
    check_val("wr_err", 64'(exp_wr_err), 64'(rsp_i.wr_err));
    if (exp_rd_ack || exp_rd_err) check_val("rd_data", 64'(exp_rd_data), 64'(rsp_i.rd_data));
    check_val("cmd_rvalid", 64'(cmd_n != 0), 64'(cmd_rvalid_i));
    if (cmd_n != 0) check_val("cmd_rdata", cmd_q[0], cmd_rdata_i);
    check_val("cmd_full", 64'(cmd_n == int'(hci_pkg::CmdDepth)), 64'(cmd_full_i));
    check_val("cmd_empty", 64'(cmd_n == 0), 64'(cmd_empty_i));
    // Free entries against the threshold
    check_val("cmd_thld_trig", 64'(int'(hci_pkg::CmdDepth) - cmd_n >= int'(cmd_eff)),
              64'(cmd_thld_trig_i));
    check_val("resp_wready", 64'(resp_n < int'(hci_pkg::RespDepth)), 64'(resp_wready_i));
    check_val("resp_full", 64'(resp_n == int'(hci_pkg::RespDepth)), 64'(resp_full_i));
    check_val("resp_empty", 64'(resp_n == 0), 64'(resp_empty_i));
    check_val("resp_thld_trig", 64'(resp_n >= int'(resp_eff)), 64'(resp_thld_trig_i));
  endtask

  task automatic update_model();
    int                 cmd_n;
    int                 resp_n;
    logic               cmd_pop, resp_push, thld_wr, set_cmd_rst, set_resp_rst;
    logic               n_rd_ack, n_rd_err, n_wr_ack, n_wr_err;
    hci_pkg::csr_data_t n_rd_data;
    cmd_n        = cmd_q.size();
    resp_n       = resp_q.size();
    cmd_pop      = (cmd_n != 0) && cmd_rready_i;
    resp_push    = resp_wvalid_i && (resp_n < int'(hci_pkg::RespDepth));
    thld_wr      = 1'b0;
    set_cmd_rst  = 1'b0;
    set_resp_rst = 1'b0;
    n_rd_ack     = 1'b0;
    n_rd_err     = 1'b0;
    n_wr_ack     = 1'b0;
    n_wr_err     = 1'b0;
    n_rd_data    = '0;
    if (req_i.req && req_i.is_wr) begin
      case (req_i.addr)
        hci_pkg::AddrResetCtrl: begin
          n_wr_ack     = 1'b1;
          set_cmd_rst  = req_i.wr_data[hci_pkg::CmdRstBit];
          set_resp_rst = req_i.wr_data[hci_pkg::RespRstBit];
        end
        hci_pkg::AddrCmdPort: begin
          if (!asm_hi) begin
            n_wr_ack = 1'b1;
            lo_word  = req_i.wr_data;
          end else if (cmd_n == int'(hci_pkg::CmdDepth)) begin
            n_wr_err = 1'b1;  // Command dropped
          end else begin
            n_wr_ack = 1'b1;
            cmd_q.push_back({req_i.wr_data, lo_word});
          end
          asm_hi = !asm_hi;
        end
        hci_pkg::AddrThldCtrl: begin
          n_wr_ack = 1'b1;
          thld_wr  = 1'b1;
        end
        default: n_wr_err = 1'b1;
      endcase
    end else if (req_i.req) begin
      case (req_i.addr)
        hci_pkg::AddrResetCtrl: begin
          n_rd_ack = 1'b1;
          n_rd_data[hci_pkg::CmdRstBit]  = (cmd_rst_cnt != 0);
          n_rd_data[hci_pkg::RespRstBit] = (resp_rst_cnt != 0);
        end
        hci_pkg::AddrThldCtrl: begin
          n_rd_ack  = 1'b1;
          n_rd_data = {16'd0, resp_reg, cmd_reg};
        end
        hci_pkg::AddrRespPort: begin
          if (resp_n == 0) begin
            n_rd_err = 1'b1;
          end else begin
            n_rd_ack  = 1'b1;
            n_rd_data = resp_q.pop_front();
          end
        end
        default: n_rd_err = 1'b1;
      endcase
    end
    if (cmd_pop) cmd_q.delete(0);
    if (resp_push) resp_q.push_back(resp_wdata_i);

    // Clamped values land two cycles after the write
    if (wb_cnt == 1) begin
      cmd_reg  = clamp(cmd_reg, hci_pkg::CmdDepth);
      resp_reg = clamp(resp_reg, hci_pkg::RespDepth);
      cmd_eff  = cmd_reg;
      resp_eff = resp_reg;
    end
    if (wb_cnt != 0) wb_cnt--;
    if (thld_wr) begin
      cmd_reg  = req_i.wr_data[hci_pkg::CmdThldLsb +: hci_pkg::ThldWidth];
      resp_reg = req_i.wr_data[hci_pkg::RespThldLsb +: hci_pkg::ThldWidth];
      wb_cnt   = 2;
    end

    // Reset bit stays set two cycles and empties the queue
    if (cmd_rst_cnt != 0) begin
      cmd_q.delete();
      asm_hi = 1'b0;
      cmd_rst_cnt--;
    end
    if (resp_rst_cnt != 0) begin
      resp_q.delete();
      resp_rst_cnt--;
    end
    if (set_cmd_rst) cmd_rst_cnt = 2;
    if (set_resp_rst) resp_rst_cnt = 2;

    exp_rd_ack  = n_rd_ack;
    exp_rd_err  = n_rd_err;
    exp_wr_ack  = n_wr_ack;
    exp_wr_err  = n_wr_err;
    exp_rd_data = n_rd_data;
  endtask

  // Inputs change after the rising edge, so both sides are settled here
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      check_outputs();
      update_model();
    end
  end

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

endmodule

// File: tests/hci_asserts.sv
/* CSR handshake, command hold and response ready assertions, bound into hci */
`timescale 1ns/1ps

module hci_asserts (
  input logic                clk_i,
  input logic                rst_ni,
  input hci_pkg::cpuif_req_t req_i,
  input hci_pkg::cpuif_rsp_t rsp_i,
  input logic                cmd_rvalid_i,
  input logic                cmd_rready_i,
  input hci_pkg::cmd_data_t  cmd_rdata_i,
  input logic                resp_wready_i,
  input logic                resp_full_i
);

  logic [3:0] rsp_bits;

  assign rsp_bits = {rsp_i.wr_ack, rsp_i.wr_err, rsp_i.rd_ack, rsp_i.rd_err};

  a_wr_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req && req_i.is_wr |=> $onehot(rsp_bits) && (rsp_i.wr_ack || rsp_i.wr_err))
    else $error("Write request without exactly one write ack or error");

  a_rd_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req && !req_i.is_wr |=> $onehot(rsp_bits) && (rsp_i.rd_ack || rsp_i.rd_err))
    else $error("Read request without exactly one read ack or error");

  a_no_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_i.req |=> rsp_bits == 4'b0000)
    else $error("CSR response without a request");

  // A flush may drop the entry, otherwise it must hold
  a_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_rvalid_i && !cmd_rready_i |=> $stable(cmd_rdata_i) || !cmd_rvalid_i)
    else $error("Command data changed while stalled");

  a_resp_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_full_i |-> !resp_wready_i)
    else $error("Response ready while queue is full");

endmodule

bind hci hci_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .req_i         (cpuif_req_i),
  .rsp_i         (cpuif_rsp_o),
  .cmd_rvalid_i  (cmd_rvalid_o),
  .cmd_rready_i  (cmd_rready_i),
  .cmd_rdata_i   (cmd_rdata_o),
  .resp_wready_i (resp_wready_o),
  .resp_full_i   (resp_full_o)
);

// File: logic/hci.sv
/* HCI front end top: register block with command and response queues */
`timescale 1ns/1ps

module hci (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  hci_pkg::cpuif_req_t cpuif_req_i,
  output hci_pkg::cpuif_rsp_t cpuif_rsp_o,
  // Command drain toward the bus controller
  output logic                cmd_rvalid_o,
  input  logic                cmd_rready_i,
  output hci_pkg::cmd_data_t  cmd_rdata_o,
  // Response fill from the bus controller
  input  logic                resp_wvalid_i,
  output logic                resp_wready_o,
  input  hci_pkg::resp_data_t resp_wdata_i,
  output logic                cmd_full_o,
  output logic                cmd_empty_o,
  output logic                cmd_thld_trig_o,
  output logic                resp_full_o,
  output logic                resp_empty_o,
  output logic                resp_thld_trig_o
);

  hci_pkg::cmd_port_t   cmd_port;
  hci_pkg::queue_thld_t cmd_thld, resp_thld;
  hci_pkg::thld_t       cmd_thld_clamped, resp_thld_clamped;
  hci_pkg::resp_data_t  resp_rdata;
  logic                 resp_pop;
  logic                 cmd_rst, resp_rst;
  logic                 cmd_rst_done, resp_rst_done;
  logic                 cmd_accept, resp_accept;

  hci_csr u_csr (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (cpuif_req_i),
    .rsp_o           (cpuif_rsp_o),
    .cmd_port_o      (cmd_port),
    .resp_pop_o      (resp_pop),
    .cmd_thld_o      (cmd_thld),
    .resp_thld_o     (resp_thld),
    .cmd_rst_o       (cmd_rst),
    .resp_rst_o      (resp_rst),
    .cmd_accept_i    (cmd_accept),
    .resp_accept_i   (resp_accept),
    .resp_rdata_i    (resp_rdata),
    .cmd_rst_done_i  (cmd_rst_done),
    .resp_rst_done_i (resp_rst_done),
    .cmd_thld_i      (cmd_thld_clamped),
    .resp_thld_i     (resp_thld_clamped)
  );

  hci_cmd_queue u_cmd_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .port_i      (cmd_port),
    .thld_i      (cmd_thld),
    .soft_rst_i  (cmd_rst),
    .accept_o    (cmd_accept),
    .rst_done_o  (cmd_rst_done),
    .thld_o      (cmd_thld_clamped),
    .rvalid_o    (cmd_rvalid_o),
    .rready_i    (cmd_rready_i),
    .rdata_o     (cmd_rdata_o),
    .full_o      (cmd_full_o),
    .empty_o     (cmd_empty_o),
    .thld_trig_o (cmd_thld_trig_o)
  );

  hci_resp_queue u_resp_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pop_i       (resp_pop),
    .thld_i      (resp_thld),
    .soft_rst_i  (resp_rst),
    .accept_o    (resp_accept),
    .rdata_o     (resp_rdata),
    .rst_done_o  (resp_rst_done),
    .thld_o      (resp_thld_clamped),
    .wvalid_i    (resp_wvalid_i),
    .wready_o    (resp_wready_o),
    .wdata_i     (resp_wdata_i),
    .full_o      (resp_full_o),
    .empty_o     (resp_empty_o),
    .thld_trig_o (resp_thld_trig_o)
  );

endmodule

// File: logic/hci_csr.sv
/* Register block: address decode, reset and threshold registers, queue
   port strobes and registered CSR acknowledges */
`timescale 1ns/1ps

module hci_csr (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  hci_pkg::cpuif_req_t  req_i,
  output hci_pkg::cpuif_rsp_t  rsp_o,
  output hci_pkg::cmd_port_t   cmd_port_o,
  output logic                 resp_pop_o,
  output hci_pkg::queue_thld_t cmd_thld_o,
  output hci_pkg::queue_thld_t resp_thld_o,
  output logic                 cmd_rst_o,
  output logic                 resp_rst_o,
  input  logic                 cmd_accept_i,
  input  logic                 resp_accept_i,
  input  hci_pkg::resp_data_t  resp_rdata_i,
  input  logic                 cmd_rst_done_i,
  input  logic                 resp_rst_done_i,
  input  hci_pkg::thld_t       cmd_thld_i,
  input  hci_pkg::thld_t       resp_thld_i
);

  logic               wr_req, rd_req;
  logic               hit_rst, hit_cmd, hit_resp, hit_thld;
  logic               wr_ok, rd_ok;
  logic               thld_wr;
  logic [1:0]         thld_wr_q;  // Write-back delay line
  logic               cmd_rst_q, resp_rst_q;
  hci_pkg::thld_t     cmd_thld_q, resp_thld_q;
  logic               rd_ack_q, rd_err_q, wr_ack_q, wr_err_q;
  logic               resp_rd_q;
  hci_pkg::csr_data_t rd_data_d, rd_data_q;

  assign wr_req   = req_i.req & req_i.is_wr;
  assign rd_req   = req_i.req & ~req_i.is_wr;
  assign hit_rst  = (req_i.addr == hci_pkg::AddrResetCtrl);
  assign hit_cmd  = (req_i.addr == hci_pkg::AddrCmdPort);
  assign hit_resp = (req_i.addr == hci_pkg::AddrRespPort);
  assign hit_thld = (req_i.addr == hci_pkg::AddrThldCtrl);

  // Port registers only work in their own direction
  assign wr_ok   = hit_rst | hit_thld | (hit_cmd & cmd_accept_i);
  assign rd_ok   = hit_rst | hit_thld | (hit_resp & resp_accept_i);
  assign thld_wr = wr_req & hit_thld;

  assign cmd_port_o.wr   = wr_req & hit_cmd;
  assign cmd_port_o.data = req_i.wr_data;
  assign resp_pop_o      = rd_req & hit_resp;

  always_comb begin
    rd_data_d = '0;
    if (rd_req && hit_rst) begin
      rd_data_d[hci_pkg::CmdRstBit]  = cmd_rst_q;
      rd_data_d[hci_pkg::RespRstBit] = resp_rst_q;
    end else if (rd_req && hit_thld) begin
      rd_data_d[hci_pkg::CmdThldLsb +: hci_pkg::ThldWidth]  = cmd_thld_q;
      rd_data_d[hci_pkg::RespThldLsb +: hci_pkg::ThldWidth] = resp_thld_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q  <= 1'b0;
      rd_err_q  <= 1'b0;
      wr_ack_q  <= 1'b0;
      wr_err_q  <= 1'b0;
      resp_rd_q <= 1'b0;
      thld_wr_q <= '0;
    end else begin
      rd_ack_q  <= rd_req & rd_ok;
      rd_err_q  <= rd_req & ~rd_ok;
      wr_ack_q  <= wr_req & wr_ok;
      wr_err_q  <= wr_req & ~wr_ok;
      resp_rd_q <= rd_req & hit_resp & resp_accept_i;  // Data comes from the queue
      thld_wr_q <= {thld_wr_q[0], thld_wr};
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_q <= rd_data_d;
  end

  // Software write wins over the clamped write-back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= hci_pkg::ThldRstVal;
      resp_thld_q <= hci_pkg::ThldRstVal;
    end else if (thld_wr) begin
      cmd_thld_q  <= req_i.wr_data[hci_pkg::CmdThldLsb +: hci_pkg::ThldWidth];
      resp_thld_q <= req_i.wr_data[hci_pkg::RespThldLsb +: hci_pkg::ThldWidth];
    end else if (thld_wr_q[1]) begin
      cmd_thld_q  <= cmd_thld_i;
      resp_thld_q <= resp_thld_i;
    end
  end

  // Reset bits are set by software and cleared by the queue's done pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q  <= 1'b0;
      resp_rst_q <= 1'b0;
    end else begin
      if (wr_req && hit_rst && req_i.wr_data[hci_pkg::CmdRstBit]) cmd_rst_q <= 1'b1;
      else if (cmd_rst_done_i) cmd_rst_q <= 1'b0;
      if (wr_req && hit_rst && req_i.wr_data[hci_pkg::RespRstBit]) resp_rst_q <= 1'b1;
      else if (resp_rst_done_i) resp_rst_q <= 1'b0;
    end
  end

  assign cmd_rst_o         = cmd_rst_q;
  assign resp_rst_o        = resp_rst_q;
  assign cmd_thld_o.value  = cmd_thld_q;
  assign cmd_thld_o.we     = thld_wr_q[1];
  assign resp_thld_o.value = resp_thld_q;
  assign resp_thld_o.we    = thld_wr_q[1];

  assign rsp_o.rd_ack  = rd_ack_q;
  assign rsp_o.rd_err  = rd_err_q;
  assign rsp_o.rd_data = resp_rd_q ? resp_rdata_i : rd_data_q;
  assign rsp_o.wr_ack  = wr_ack_q;
  assign rsp_o.wr_err  = wr_err_q;

endmodule

// File: logic/hci_resp_queue.sv
/* Response queue: filled by the controller, popped by CSR reads */
`timescale 1ns/1ps

module hci_resp_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 pop_i,
  input  hci_pkg::queue_thld_t thld_i,
  input  logic                 soft_rst_i,
  output logic                 accept_o,
  output hci_pkg::resp_data_t  rdata_o,
  output logic                 rst_done_o,
  output hci_pkg::thld_t       thld_o,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  hci_pkg::resp_data_t  wdata_i,
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 thld_trig_o
);

  hci_pkg::resp_data_t head_data;
  hci_pkg::resp_data_t rdata_q;
  hci_pkg::count_t     count;
  hci_pkg::thld_t      thld_q;
  logic                done_q;

  assign wready_o = ~full_o;
  assign accept_o = ~empty_o;  // Pop only succeeds with data present

  hci_fifo #(
    .Depth     (hci_pkg::RespDepth),
    .DataWidth (hci_pkg::RespDataWidth)
  ) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (soft_rst_i),
    .wr_en_i   (wvalid_i & wready_o),
    .wr_data_i (wdata_i),
    .rd_en_i   (pop_i),
    .rd_data_o (head_data),
    .count_o   (count),
    .full_o    (full_o),
    .empty_o   (empty_o)
  );

  // Held for the read response one cycle later
  always_ff @(posedge clk_i) begin
    if (pop_i && !empty_o) rdata_q <= head_data;
  end

  assign rdata_o = rdata_q;

  always_comb begin
    if (thld_i.value == '0) thld_o = hci_pkg::thld_t'(1);
    else if (thld_i.value > hci_pkg::thld_t'(hci_pkg::RespDepth))
      thld_o = hci_pkg::thld_t'(hci_pkg::RespDepth);
    else thld_o = thld_i.value;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_q <= hci_pkg::ThldRstVal;
      done_q <= 1'b0;
    end else begin
      if (thld_i.we) thld_q <= thld_o;
      done_q <= soft_rst_i & ~done_q;  // One pulse per reset request
    end
  end

  assign rst_done_o  = done_q;
  assign thld_trig_o = (hci_pkg::thld_t'(count) >= thld_q);

endmodule

// File: logic/hci_cmd_queue.sv
/* Command queue: joins two CSR words into one entry, free-space threshold */
`timescale 1ns/1ps

module hci_cmd_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  hci_pkg::cmd_port_t   port_i,
  input  hci_pkg::queue_thld_t thld_i,
  input  logic                 soft_rst_i,
  output logic                 accept_o,
  output logic                 rst_done_o,
  output hci_pkg::thld_t       thld_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output hci_pkg::cmd_data_t   rdata_o,
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 thld_trig_o
);

  hci_pkg::cmd_asm_e  state_q;
  hci_pkg::csr_data_t lo_word_q;
  hci_pkg::thld_t     thld_q;
  hci_pkg::thld_t     free_slots;
  hci_pkg::count_t    count;
  logic               push;
  logic               done_q;

  assign push     = port_i.wr & (state_q == hci_pkg::cmd_hi_e);
  assign accept_o = (state_q == hci_pkg::cmd_lo_e) | ~full_o;  // Only second word can fail

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= hci_pkg::cmd_lo_e;
    end else if (soft_rst_i) begin
      state_q <= hci_pkg::cmd_lo_e;  // Drop half-built command
    end else if (port_i.wr) begin
      if (state_q == hci_pkg::cmd_lo_e) state_q <= hci_pkg::cmd_hi_e;
      else state_q <= hci_pkg::cmd_lo_e;
    end
  end

  always_ff @(posedge clk_i) begin
    if (port_i.wr && state_q == hci_pkg::cmd_lo_e) lo_word_q <= port_i.data;
  end

  hci_fifo #(
    .Depth     (hci_pkg::CmdDepth),
    .DataWidth (hci_pkg::CmdDataWidth)
  ) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (soft_rst_i),
    .wr_en_i   (push),
    .wr_data_i ({port_i.data, lo_word_q}),
    .rd_en_i   (rvalid_o & rready_i),
    .rd_data_o (rdata_o),
    .count_o   (count),
    .full_o    (full_o),
    .empty_o   (empty_o)
  );

  assign rvalid_o = ~empty_o;

  // Clamp to 1..CmdDepth
  always_comb begin
    if (thld_i.value == '0) thld_o = hci_pkg::thld_t'(1);
    else if (thld_i.value > hci_pkg::thld_t'(hci_pkg::CmdDepth))
      thld_o = hci_pkg::thld_t'(hci_pkg::CmdDepth);
    else thld_o = thld_i.value;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_q <= hci_pkg::ThldRstVal;
      done_q <= 1'b0;
    end else begin
      if (thld_i.we) thld_q <= thld_o;  // Follows register write-back
      done_q <= soft_rst_i & ~done_q;
    end
  end

  assign rst_done_o  = done_q;
  assign free_slots  = hci_pkg::thld_t'(hci_pkg::CmdDepth) - hci_pkg::thld_t'(count);
  assign thld_trig_o = (free_slots >= thld_q);

endmodule

// File: logic/hci_fifo.sv
/* Synchronous FIFO with occupancy count, single-cycle flush and flags */
`timescale 1ns/1ps

module hci_fifo #(
  parameter int unsigned Depth     = hci_pkg::CmdDepth,
  parameter int unsigned DataWidth = hci_pkg::CsrDataWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 wr_en_i,
  input  logic [DataWidth-1:0] wr_data_i,
  input  logic                 rd_en_i,
  output logic [DataWidth-1:0] rd_data_o,
  output hci_pkg::count_t      count_o,
  output logic                 full_o,
  output logic                 empty_o
);

  localparam int unsigned PtrWidth = $clog2(Depth);

  logic [DataWidth-1:0] mem_q [Depth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  hci_pkg::count_t      count_q;
  logic                 do_wr;
  logic                 do_rd;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == hci_pkg::count_t'(Depth));
  assign empty_o = (count_q == '0);
  assign do_wr   = wr_en_i & ~full_o;  // Dropped when full
  assign do_rd   = rd_en_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_rd) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + hci_pkg::count_t'(do_wr) - hci_pkg::count_t'(do_rd);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) mem_q[wr_ptr_q] <= wr_data_i;
  end

  assign rd_data_o = mem_q[rd_ptr_q];  // Head entry, valid while not empty
  assign count_o   = count_q;

endmodule

// File: logic/hci_pkg.sv
/* Widths, queue depths, CSR map, vector types, structs and the command
   assembly enum shared by the HCI front end */
package hci_pkg;

  localparam int unsigned CsrDataWidth  = 32;
  localparam int unsigned CsrAddrWidth  = 8;
  localparam int unsigned CmdDataWidth  = 64;
  localparam int unsigned RespDataWidth = 32;
  localparam int unsigned ThldWidth     = 8;
  localparam int unsigned CmdDepth      = 8;
  localparam int unsigned RespDepth     = 8;
  localparam int unsigned CountWidth    = 4;  // Holds 0..Depth

  typedef logic [CsrDataWidth-1:0]  csr_data_t;
  typedef logic [CsrAddrWidth-1:0]  csr_addr_t;
  typedef logic [CmdDataWidth-1:0]  cmd_data_t;
  typedef logic [RespDataWidth-1:0] resp_data_t;
  typedef logic [ThldWidth-1:0]     thld_t;
  typedef logic [CountWidth-1:0]    count_t;

  // CSR byte addresses
  localparam csr_addr_t AddrResetCtrl = 8'h04;
  localparam csr_addr_t AddrCmdPort   = 8'h0C;  // Write only
  localparam csr_addr_t AddrRespPort  = 8'h10;  // Read only
  localparam csr_addr_t AddrThldCtrl  = 8'h14;

  localparam int unsigned CmdRstBit   = 1;
  localparam int unsigned RespRstBit  = 2;
  localparam int unsigned CmdThldLsb  = 0;
  localparam int unsigned RespThldLsb = 8;
  localparam thld_t       ThldRstVal  = 8'd1;

  typedef struct packed {
    logic      req;
    logic      is_wr;
    csr_addr_t addr;
    csr_data_t wr_data;
  } cpuif_req_t;

  typedef struct packed {
    logic      rd_ack;
    logic      rd_err;
    csr_data_t rd_data;
    logic      wr_ack;
    logic      wr_err;
  } cpuif_rsp_t;

  // One CSR word headed for the command queue
  typedef struct packed {
    logic      wr;
    csr_data_t data;
  } cmd_port_t;

  typedef struct packed {
    thld_t value;
    logic  we;  // Write-back slot for the clamped value
  } queue_thld_t;

  typedef enum logic {
    cmd_lo_e,
    cmd_hi_e
  } cmd_asm_e;

endpackage
